// ==== bench/ex_unit_checker.sv ====
`timescale 1ns/1ps

module ex_unit_checker (
    input logic clk_i,
    input logic rst_i,
    input logic issue_i,
    input logic done_i,
    input logic busy_i
);

    // high once a reset edge has been seen, so outputs are defined
    logic in_reset_q = 1'b0;

    always @(posedge clk_i) begin
        in_reset_q <= rst_i;
    end

    // outputs held idle across reset
    reset_idle: assert property (@(posedge clk_i) in_reset_q |-> !done_i && !busy_i)
        else $error("done or busy high during reset");

    // issue only while the divider is idle
    issue_when_idle: assert property (@(posedge clk_i) disable iff (rst_i) !(issue_i && busy_i))
        else $error("issue while busy");

    // a divide completes with a single done pulse
    single_done: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(busy_i) ##1 done_i |-> $past(issue_i))
        else $error("done high on two consecutive cycles after a divide");

    no_done_while_busy: assert property (@(posedge clk_i) disable iff (rst_i) busy_i |-> !done_i)
        else $error("done high while busy");

    busy_falls_on_done: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(busy_i) |-> done_i)
        else $error("busy fell without a done pulse");

endmodule

bind ex_unit ex_unit_checker i_checker (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .done_i  (done_o),
    .busy_i  (busy_o)
);

// ==== bench/ex_unit_tb.sv ====
`timescale 1ns/1ps

module ex_unit_tb;

    // issue counts per test group
    localparam int N_ALU_RAND = 8 * 2 * 2 * 6;
    localparam int N_ALU_EDGE = 6 * 6 * 4;
    localparam int N_SHIFT    = 64 * 3 * 2;
    localparam int N_MD_EDGE  = 8 * 2 * 6 * 6;
    localparam int N_MD_RAND  = 8 * 2 * 8;
    localparam int N_MIX      = 300;
    localparam int N_TOTAL    = N_ALU_RAND + N_ALU_EDGE + N_SHIFT + N_MD_EDGE + N_MD_RAND + N_MIX;
    // worst case every issue is a divide followed by the longest idle gap
    localparam int TIMEOUT_CYCLES = N_TOTAL * (rv_cfg_pkg::DIV_LATENCY + 4) + 100;

    logic        clk_i;
    logic        rst_i;
    logic        issue_i;
    logic        md_en_i;
    logic [4:0]  op_i;
    logic [63:0] src1_i;
    logic [63:0] src2_i;
    logic [63:0] result_o;
    logic        zero_o;
    logic        done_o;
    logic        busy_o;

    int          cyc = 0;
    logic [63:0] exp_res_q[$];
    logic        exp_zero_q[$];
    logic        exp_div_q[$];
    int          exp_due_q[$];

    ex_unit i_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .md_en_i  (md_en_i),
        .op_i     (op_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (result_o),
        .zero_o   (zero_o),
        .done_o   (done_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s got 0x%h expected 0x%h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [63:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [63:0] edge_val(input int idx);
        case (idx)
            0:       return 64'h0;
            1:       return 64'h1;
            2:       return 64'hffff_ffff_ffff_ffff;
            3:       return 64'h8000_0000_0000_0000;
            4:       return 64'h7fff_ffff_ffff_ffff;
            default: return 64'h0000_0000_8000_0000;
        endcase
    endfunction

    // expected {zero, result} from the RISC-V rules
    function automatic logic [64:0] ref_exec(input logic md, input logic [4:0] op,
                                             input logic [63:0] a, input logic [63:0] b);
        ex_op_pkg::ex_op_u   u;
        logic [63:0]         r;
        logic [63:0]         sum;
        logic [63:0]         x;
        logic [63:0]         y;
        logic [63:0]         q;
        logic [63:0]         rm;
        logic signed [127:0] pa;
        logic signed [127:0] pb;
        logic signed [127:0] prod;
        logic                sgn_a;
        logic                sgn_b;
        int                  sh;
        u = op;
        if (!md) begin
            if (u.alu.fn == ex_op_pkg::FN_SLT || (u.alu.fn == ex_op_pkg::FN_ADD && u.alu.alt)) begin
                sum = a - b;
            end else begin
                sum = a + b;
            end
            sh = u.alu.word ? int'(b[4:0]) : int'(b[5:0]);
            case (u.alu.fn)
                ex_op_pkg::FN_ADD:  r = sum;
                ex_op_pkg::FN_SLL:  r = a << sh;
                ex_op_pkg::FN_PASS: r = b;
                ex_op_pkg::FN_XOR:  r = a ^ b;
                ex_op_pkg::FN_OR:   r = a | b;
                ex_op_pkg::FN_AND:  r = a & b;
                ex_op_pkg::FN_SLT: begin
                    if (u.alu.alt) begin
                        r = {63'b0, a < b};
                    end else begin
                        r = {63'b0, $signed(a) < $signed(b)};
                    end
                end
                default: begin
                    // word right shifts work on the low 32 bits only
                    x = u.alu.word ? {{32{a[31]}}, a[31:0]} : a;
                    if (u.alu.alt) begin
                        r = $signed(x) >>> sh;
                    end else if (u.alu.word) begin
                        r = {32'b0, a[31:0]} >> sh;
                    end else begin
                        r = a >> sh;
                    end
                end
            endcase
            if (u.alu.word) begin
                r = {{32{r[31]}}, r[31:0]};
            end
            return {sum == 64'h0, r};
        end
        case (u.md.sel)
            ex_op_pkg::SEL_MULH: begin
                sgn_a = 1'b1;
                sgn_b = 1'b1;
            end
            ex_op_pkg::SEL_MULHSU: begin
                sgn_a = 1'b1;
                sgn_b = 1'b0;
            end
            ex_op_pkg::SEL_DIV, ex_op_pkg::SEL_REM: begin
                sgn_a = 1'b1;
                sgn_b = 1'b1;
            end
            default: begin
                sgn_a = 1'b0;
                sgn_b = 1'b0;
            end
        endcase
        x = u.md.word ? {{32{sgn_a & a[31]}}, a[31:0]} : a;
        y = u.md.word ? {{32{sgn_b & b[31]}}, b[31:0]} : b;
        if (!u.md.sel[2]) begin
            pa   = sgn_a ? {{64{x[63]}}, x} : {64'b0, x};
            pb   = sgn_b ? {{64{y[63]}}, y} : {64'b0, y};
            prod = pa * pb;
            r    = (u.md.sel == ex_op_pkg::SEL_MUL) ? prod[63:0] : prod[127:64];
        end else begin
            if (y == 64'h0) begin
                q  = '1;
                rm = x;
            end else if (sgn_a && x == 64'h8000_0000_0000_0000 && y == '1) begin
                q  = x;
                rm = 64'h0;
            end else if (sgn_a) begin
                q  = $signed(x) / $signed(y);
                rm = $signed(x) % $signed(y);
            end else begin
                q  = x / y;
                rm = x % y;
            end
            r = u.md.sel[1] ? rm : q;
        end
        if (u.md.word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return {1'b0, r};
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the sampling edge
    task automatic issue_op(input logic md, input logic [4:0] op,
                            input logic [63:0] a, input logic [63:0] b);
        logic [64:0] exp;
        logic        is_div;
        while (busy_o) begin
            @(posedge clk_i);
            #1;
        end
        exp    = ref_exec(md, op, a, b);
        is_div = md & op[2];
        exp_res_q.push_back(exp[63:0]);
        exp_zero_q.push_back(exp[64]);
        exp_div_q.push_back(is_div);
        exp_due_q.push_back(cyc + (is_div ? rv_cfg_pkg::DIV_LATENCY : 1));
        issue_i = 1'b1;
        md_en_i = md;
        op_i    = op;
        src1_i  = a;
        src2_i  = b;
        @(posedge clk_i);
        #1;
        issue_i = 1'b0;
    endtask

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            stop_run("timeout: the run went past its cycle limit");
        end
    end

    // compare completions against the queue at the falling edge
    always @(negedge clk_i) begin
        if (!rst_i && exp_res_q.size() != 0) begin
            if (exp_div_q[0] && cyc > exp_due_q[0] - rv_cfg_pkg::DIV_LATENCY &&
                cyc < exp_due_q[0]) begin
                check_val("busy_o", busy_o, 1'b1);
            end
            if (cyc >= exp_due_q[0]) begin
                check_val("done_o", done_o, 1'b1);
            end
        end
        if (!rst_i && done_o) begin
            if (exp_res_q.size() == 0) begin
                stop_run("done_o pulsed while no operation was outstanding");
            end else begin
                check_val("done_o cycle", 64'(cyc), 64'(exp_due_q[0]));
                check_val("result_o", result_o, exp_res_q[0]);
                check_val("zero_o", zero_o, exp_zero_q[0]);
                check_val("busy_o", busy_o, 1'b0);
                void'(exp_res_q.pop_front());
                void'(exp_zero_q.pop_front());
                void'(exp_div_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        logic        md;
        void'($urandom(32'h3262));
        rst_i   = 1'b1;
        issue_i = 1'b0;
        md_en_i = 1'b0;
        op_i    = 5'b0;
        src1_i  = 64'h0;
        src2_i  = 64'h0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_val("result_o", result_o, 64'h0);
        check_val("done_o", done_o, 1'b0);
        check_val("busy_o", busy_o, 1'b0);

        // every alu function in both widths
        for (int fn = 0; fn < 8; fn++) begin
            for (int alt = 0; alt < 2; alt++) begin
                for (int w = 0; w < 2; w++) begin
                    repeat (6) issue_op(1'b0, {w[0], alt[0], fn[2:0]}, rnd64(), rnd64());
                end
            end
        end
        // carry and overflow corners on add, sub, slt, sltu
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                issue_op(1'b0, {2'b00, ex_op_pkg::FN_ADD}, edge_val(i), edge_val(j));
                issue_op(1'b0, {2'b01, ex_op_pkg::FN_ADD}, edge_val(i), edge_val(j));
                issue_op(1'b0, {2'b00, ex_op_pkg::FN_SLT}, edge_val(i), edge_val(j));
                issue_op(1'b0, {2'b01, ex_op_pkg::FN_SLT}, edge_val(i), edge_val(j));
            end
        end

        // all shift amounts, upper bits of src2 must be ignored
        for (int amt = 0; amt < 64; amt++) begin
            for (int w = 0; w < 2; w++) begin
                a = rnd64();
                b = rnd64();
                b[5:0] = amt[5:0];
                if (w != 0) begin
                    a[31] = 1'b1;
                end else begin
                    a[63] = amt[0];
                end
                issue_op(1'b0, {w[0], 1'b0, ex_op_pkg::FN_SLL}, a, b);
                issue_op(1'b0, {w[0], 1'b0, ex_op_pkg::FN_SR}, a, b);
                issue_op(1'b0, {w[0], 1'b1, ex_op_pkg::FN_SR}, a, b);
            end
        end

        // multiply and divide forms, extremes then random
        for (int sel = 0; sel < 8; sel++) begin
            for (int w = 0; w < 2; w++) begin
                for (int i = 0; i < 6; i++) begin
                    for (int j = 0; j < 6; j++) begin
                        issue_op(1'b1, {w[0], 1'b0, sel[2:0]}, edge_val(i), edge_val(j));
                    end
                end
                repeat (8) issue_op(1'b1, {w[0], 1'b0, sel[2:0]}, rnd64(), rnd64());
            end
        end

        // random mix with idle gaps
        repeat (N_MIX) begin
            md = $urandom_range(0, 1);
            a  = ($urandom_range(0, 3) == 0) ? edge_val($urandom_range(0, 5)) : rnd64();
            b  = ($urandom_range(0, 3) == 0) ? edge_val($urandom_range(0, 5)) : rnd64();
            issue_op(md, 5'($urandom_range(0, 31)), a, b);
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk_i);
                #1;
            end
        end

        for (int i = 0; i < rv_cfg_pkg::DIV_LATENCY + 2 && exp_res_q.size() != 0; i++) begin
            @(posedge clk_i);
        end
        if (exp_res_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_run("results still outstanding after the last issue");
        end
    end

endmodule

// ==== filelist.f ====
rtl/rv_cfg_pkg.sv
rtl/ex_op_pkg.sv
rtl/alu_adder.sv
rtl/alu_shifter.sv
rtl/alu.sv
rtl/muldiv.sv
rtl/ex_unit.sv
bench/ex_unit_checker.sv
bench/ex_unit_tb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ex_op_pkg::ex_op_u           op_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src1_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src2_i,
    output logic [rv_cfg_pkg::XLEN-1:0] result_o,
    output logic                        zero_o
);

    ex_op_pkg::alu_ctl_t         ctl;
    logic                        sub;
    logic                        uns;
    logic                        right;
    logic                        arith;
    logic [rv_cfg_pkg::XLEN-1:0] sum;
    logic                        less;
    logic [rv_cfg_pkg::XLEN-1:0] shift;
    logic [rv_cfg_pkg::XLEN-1:0] alu_out;

    assign ctl = op_i.alu;

    // compares always subtract, add only when alt is set
    assign sub   = (ctl.fn == ex_op_pkg::FN_SLT) || ((ctl.fn == ex_op_pkg::FN_ADD) && ctl.alt);
    assign uns   = ctl.alt;
    assign right = ctl.fn[2];
    assign arith = ctl.alt;

    alu_adder i_adder (
        .a_i        (src1_i),
        .b_i        (src2_i),
        .sub_i      (sub),
        .unsigned_i (uns),
        .sum_o      (sum),
        .zero_o     (zero_o),
        .less_o     (less)
    );

    alu_shifter i_shifter (
        .src_i   (src1_i),
        .shamt_i (src2_i[rv_cfg_pkg::SHAMT_W-1:0]),
        .right_i (right),
        .arith_i (arith),
        .word_i  (ctl.word),
        .shift_o (shift)
    );

    always_comb begin
        case (ctl.fn)
            ex_op_pkg::FN_ADD: begin
                alu_out = sum;
            end
            ex_op_pkg::FN_SLL, ex_op_pkg::FN_SR: begin
                alu_out = shift;
            end
            ex_op_pkg::FN_SLT: begin
                alu_out = {{(rv_cfg_pkg::XLEN-1){1'b0}}, less};
            end
            ex_op_pkg::FN_PASS: begin
                alu_out = src2_i;
            end
            ex_op_pkg::FN_XOR: begin
                alu_out = src1_i ^ src2_i;
            end
            ex_op_pkg::FN_OR: begin
                alu_out = src1_i | src2_i;
            end
            default: begin
                alu_out = src1_i & src2_i;
            end
        endcase
    end

    // word forms sign-extend from bit 31
    assign result_o = ctl.word ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){alu_out[rv_cfg_pkg::WLEN-1]}},
         alu_out[rv_cfg_pkg::WLEN-1:0]} : alu_out;

endmodule

// ==== rtl/alu_adder.sv ====
`timescale 1ns/1ps

module alu_adder (
    input  logic [rv_cfg_pkg::XLEN-1:0] a_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] b_i,
    input  logic                        sub_i,
    input  logic                        unsigned_i,
    output logic [rv_cfg_pkg::XLEN-1:0] sum_o,
    output logic                        zero_o,
    output logic                        less_o
);

    logic [rv_cfg_pkg::XLEN-1:0] b_inv;
    logic                        carry;
    logic                        overflow;

    // two's complement subtract via inversion and carry in
    assign b_inv = b_i ^ {rv_cfg_pkg::XLEN{sub_i}};
    assign {carry, sum_o} = {1'b0, a_i} + {1'b0, b_inv} + {{rv_cfg_pkg::XLEN{1'b0}}, sub_i};

    // operands agree in sign but the sum does not
    assign overflow = (a_i[rv_cfg_pkg::XLEN-1] == b_inv[rv_cfg_pkg::XLEN-1]) &&
                      (sum_o[rv_cfg_pkg::XLEN-1] != a_i[rv_cfg_pkg::XLEN-1]);

    // no carry out on a subtract means borrow
    assign less_o = unsigned_i ? (carry ^ sub_i) : (sum_o[rv_cfg_pkg::XLEN-1] ^ overflow);

    assign zero_o = ~(|sum_o);

endmodule

// ==== rtl/alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter (
    input  logic [rv_cfg_pkg::XLEN-1:0]    src_i,
    input  logic [rv_cfg_pkg::SHAMT_W-1:0] shamt_i,
    input  logic                           right_i,
    input  logic                           arith_i,
    input  logic                           word_i,
    output logic [rv_cfg_pkg::XLEN-1:0]    shift_o
);

    logic [rv_cfg_pkg::SHAMT_W-1:0] amt;
    logic                           sign;
    logic [rv_cfg_pkg::XLEN-1:0]    word_src;
    logic [rv_cfg_pkg::XLEN-1:0]    shift_in;
    logic [rv_cfg_pkg::XLEN-1:0]    shift_raw;
    logic [rv_cfg_pkg::XLEN-1:0]    fill_mask;

    function automatic logic [rv_cfg_pkg::XLEN-1:0] bit_rev(
        input logic [rv_cfg_pkg::XLEN-1:0] v
    );
        logic [rv_cfg_pkg::XLEN-1:0] r;
        for (int i = 0; i < rv_cfg_pkg::XLEN; i++) begin
            r[i] = v[rv_cfg_pkg::XLEN-1-i];
        end
        return r;
    endfunction

    // word shifts only honour 5 amount bits
    assign amt = word_i ? {1'b0, shamt_i[rv_cfg_pkg::SHAMT_W-2:0]} : shamt_i;

    // fill bit for arithmetic right shifts
    assign sign = arith_i & (word_i ? src_i[rv_cfg_pkg::WLEN-1] : src_i[rv_cfg_pkg::XLEN-1]);

    // upper half of a word operand replaced by its fill
    assign word_src = word_i ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){sign}}, src_i[rv_cfg_pkg::WLEN-1:0]} : src_i;

    // left shift = reverse, shift right, reverse back
    assign shift_in  = right_i ? word_src : bit_rev(src_i);
    assign shift_raw = shift_in >> amt;

    // bits vacated at the top by the right shift
    assign fill_mask = ~({rv_cfg_pkg::XLEN{1'b1}} >> amt);

    assign shift_o = right_i ? (shift_raw | (fill_mask & {rv_cfg_pkg::XLEN{sign}}))
                             : bit_rev(shift_raw);

endmodule

// ==== rtl/ex_op_pkg.sv ====
package ex_op_pkg;

    // alu reading of the operation word
    typedef struct packed {
        logic       word;
        logic       alt;
        logic [2:0] fn;
    } alu_ctl_t;

    // multiply/divide reading of the operation word
    typedef struct packed {
        logic       word;
        logic       rsvd;
        logic [2:0] sel;
    } md_ctl_t;

    // one 5-bit word, decoded per md_en
    typedef union packed {
        alu_ctl_t alu;
        md_ctl_t  md;
    } ex_op_u;

    // alu fn codes, alt picks sub / unsigned / arithmetic
    localparam logic [2:0] FN_ADD  = 3'b000;
    localparam logic [2:0] FN_SLL  = 3'b001;
    localparam logic [2:0] FN_SLT  = 3'b010;
    localparam logic [2:0] FN_PASS = 3'b011;
    localparam logic [2:0] FN_XOR  = 3'b100;
    localparam logic [2:0] FN_SR   = 3'b101;
    localparam logic [2:0] FN_OR   = 3'b110;
    localparam logic [2:0] FN_AND  = 3'b111;

    // multiply/divide select codes, bit 2 marks a divide
    localparam logic [2:0] SEL_MUL    = 3'b000;
    localparam logic [2:0] SEL_MULH   = 3'b001;
    localparam logic [2:0] SEL_MULHSU = 3'b010;
    localparam logic [2:0] SEL_MULHU  = 3'b011;
    localparam logic [2:0] SEL_DIV    = 3'b100;
    localparam logic [2:0] SEL_DIVU   = 3'b101;
    localparam logic [2:0] SEL_REM    = 3'b110;
    localparam logic [2:0] SEL_REMU   = 3'b111;

endpackage

// ==== rtl/ex_unit.sv ====
`timescale 1ns/1ps

module ex_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        issue_i,
    input  logic                        md_en_i,
    input  logic [4:0]                  op_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src1_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src2_i,
    output logic [rv_cfg_pkg::XLEN-1:0] result_o,
    output logic                        zero_o,
    output logic                        done_o,
    output logic                        busy_o
);

    ex_op_pkg::ex_op_u           op;
    logic                        accept;
    logic                        md_start;
    logic [rv_cfg_pkg::XLEN-1:0] alu_res;
    logic                        alu_zero;
    logic                        md_busy;
    logic                        md_done;
    logic [rv_cfg_pkg::XLEN-1:0] md_result;
    logic                        alu_done_q;
    logic [rv_cfg_pkg::XLEN-1:0] alu_res_q;
    logic                        alu_zero_q;

    assign op = op_i;

    // issues during a divide are dropped
    assign accept   = issue_i & ~md_busy;
    assign md_start = accept & md_en_i;

    alu i_alu (
        .op_i     (op),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (alu_res),
        .zero_o   (alu_zero)
    );

    muldiv i_muldiv (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (md_start),
        .op_i     (op),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .busy_o   (md_busy),
        .done_o   (md_done),
        .result_o (md_result)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            alu_done_q <= 1'b0;
        end else begin
            alu_done_q <= accept & ~md_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !md_en_i) begin
            alu_res_q  <= alu_res;
            alu_zero_q <= alu_zero;
        end
    end

    // one op in flight, so the two completions never coincide
    assign done_o   = alu_done_q | md_done;
    assign result_o = alu_done_q ? alu_res_q : md_result;
    assign zero_o   = alu_done_q & alu_zero_q;
    assign busy_o   = md_busy;

endmodule

// ==== rtl/muldiv.sv ====
`timescale 1ns/1ps

module muldiv (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  ex_op_pkg::ex_op_u           op_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src1_i,
    input  logic [rv_cfg_pkg::XLEN-1:0] src2_i,
    output logic                        busy_o,
    output logic                        done_o,
    output logic [rv_cfg_pkg::XLEN-1:0] result_o
);

    ex_op_pkg::md_ctl_t              ctl;
    logic                            is_div;
    logic                            a_signed;
    logic                            b_signed;
    logic [rv_cfg_pkg::XLEN-1:0]     a_op;
    logic [rv_cfg_pkg::XLEN-1:0]     b_op;
    logic                            a_neg;
    logic                            b_neg;
    logic signed [rv_cfg_pkg::XLEN:0]     a_mul;
    logic signed [rv_cfg_pkg::XLEN:0]     b_mul;
    logic signed [2*rv_cfg_pkg::XLEN+1:0] prod;
    logic [rv_cfg_pkg::XLEN-1:0]     mul_sel;
    logic [rv_cfg_pkg::XLEN-1:0]     mul_res;
    logic                            go;
    logic                            step;
    logic                            fix;
    logic                            busy_q;
    logic                            done_q;
    logic [rv_cfg_pkg::DIV_CNT_W-1:0] cyc_q;
    logic [rv_cfg_pkg::XLEN-1:0]     rem_q;
    logic [rv_cfg_pkg::XLEN-1:0]     quo_q;
    logic [rv_cfg_pkg::XLEN-1:0]     dvs_q;
    logic [rv_cfg_pkg::XLEN-1:0]     dvd_q;
    logic                            neg_quo_q;
    logic                            neg_rem_q;
    logic                            dz_q;
    logic                            is_rem_q;
    logic                            word_q;
    logic [rv_cfg_pkg::XLEN:0]       partial;
    logic [rv_cfg_pkg::XLEN:0]       diff;
    logic [rv_cfg_pkg::XLEN-1:0]     div_pick;
    logic [rv_cfg_pkg::XLEN-1:0]     div_res;
    logic [rv_cfg_pkg::XLEN-1:0]     result_q;

    assign ctl    = op_i.md;
    assign is_div = ctl.sel[2];

    // divides are signed when sel[0] is clear, multiplies per form
    assign a_signed = is_div ? ~ctl.sel[0] :
        (ctl.sel == ex_op_pkg::SEL_MULH) || (ctl.sel == ex_op_pkg::SEL_MULHSU);
    assign b_signed = is_div ? ~ctl.sel[0] : (ctl.sel == ex_op_pkg::SEL_MULH);

    // word forms extend the low 32 bits first
    assign a_op = ctl.word ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){a_signed & src1_i[rv_cfg_pkg::WLEN-1]}},
         src1_i[rv_cfg_pkg::WLEN-1:0]} : src1_i;
    assign b_op = ctl.word ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){b_signed & src2_i[rv_cfg_pkg::WLEN-1]}},
         src2_i[rv_cfg_pkg::WLEN-1:0]} : src2_i;

    assign a_neg = a_signed & a_op[rv_cfg_pkg::XLEN-1];
    assign b_neg = b_signed & b_op[rv_cfg_pkg::XLEN-1];

    // 65x65 signed product covers every sign mix
    assign a_mul = {a_neg, a_op};
    assign b_mul = {b_neg, b_op};
    assign prod  = a_mul * b_mul;

    assign mul_sel = (ctl.sel == ex_op_pkg::SEL_MUL) ? prod[rv_cfg_pkg::XLEN-1:0]
                                                     : prod[2*rv_cfg_pkg::XLEN-1:rv_cfg_pkg::XLEN];
    assign mul_res = ctl.word ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){mul_sel[rv_cfg_pkg::WLEN-1]}},
         mul_sel[rv_cfg_pkg::WLEN-1:0]} : mul_sel;

    // sequencer: latch, DIV_STEPS steps, then one sign fix cycle
    assign go   = start_i & ~busy_q;
    assign step = busy_q && (cyc_q <= rv_cfg_pkg::DIV_STEPS);
    assign fix  = busy_q && (cyc_q == rv_cfg_pkg::DIV_LATENCY - 1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cyc_q  <= '0;
        end else begin
            done_q <= (go & ~is_div) | fix;
            if (go && is_div) begin
                busy_q <= 1'b1;
                cyc_q  <= 1;
            end else if (fix) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cyc_q <= cyc_q + 1'b1;
            end
        end
    end

    // one restoring step on the magnitudes
    assign partial = {rem_q, quo_q[rv_cfg_pkg::XLEN-1]};
    assign diff    = partial - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (go && is_div) begin
            rem_q     <= '0;
            quo_q     <= a_neg ? -a_op : a_op;
            dvs_q     <= b_neg ? -b_op : b_op;
            dvd_q     <= a_op;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            dz_q      <= (b_op == '0);
            is_rem_q  <= ctl.sel[1];
            word_q    <= ctl.word;
        end else if (step) begin
            rem_q <= diff[rv_cfg_pkg::XLEN] ? partial[rv_cfg_pkg::XLEN-1:0]
                                            : diff[rv_cfg_pkg::XLEN-1:0];
            quo_q <= {quo_q[rv_cfg_pkg::XLEN-2:0], ~diff[rv_cfg_pkg::XLEN]};
        end
    end

    // divide by zero overrides, min / -1 falls out of the negation
    always_comb begin
        if (dz_q) begin
            div_pick = is_rem_q ? dvd_q : {rv_cfg_pkg::XLEN{1'b1}};
        end else if (is_rem_q) begin
            div_pick = neg_rem_q ? -rem_q : rem_q;
        end else begin
            div_pick = neg_quo_q ? -quo_q : quo_q;
        end
    end

    assign div_res = word_q ?
        {{(rv_cfg_pkg::XLEN-rv_cfg_pkg::WLEN){div_pick[rv_cfg_pkg::WLEN-1]}},
         div_pick[rv_cfg_pkg::WLEN-1:0]} : div_pick;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
        end else if (go && !is_div) begin
            result_q <= mul_res;
        end else if (fix) begin
            result_q <= div_res;
        end
    end

    assign busy_o   = busy_q;
    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

// ==== rtl/rv_cfg_pkg.sv ====
package rv_cfg_pkg;

    // data path widths
    localparam int XLEN    = 64;
    localparam int WLEN    = 32;
    localparam int SHAMT_W = 6;

    // restoring divider, one quotient bit per cycle
    localparam int DIV_STEPS = XLEN;

    // operand latch cycle + steps + sign fix
    localparam int DIV_LATENCY = DIV_STEPS + 2;

    // sequencer counter must reach DIV_LATENCY-1
    localparam int DIV_CNT_W = $clog2(DIV_LATENCY);

endpackage
